//--- source/m6502_pkg.sv
// Subset 6502 instruction set: only N, Z and C flags exist, there is no stack and no BCD mode
package m6502_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [15:0] addr_t;
  typedef logic [7:0]  opcode_t;

  // First opcode fetch after reset
  localparam addr_t RESET_PC = 16'h4000;

  // Group 01 instructions use the aaabbbcc layout
  localparam logic [1:0] GRP_ALU = 2'b01;

  localparam logic [2:0] MODE_ZP    = 3'b001;
  localparam logic [2:0] MODE_IMM   = 3'b010;
  localparam logic [2:0] MODE_ABS   = 3'b011;
  localparam logic [2:0] MODE_ABS_Y = 3'b110;
  localparam logic [2:0] MODE_ABS_X = 3'b111;

  localparam logic [2:0] AAA_ORA = 3'b000;
  localparam logic [2:0] AAA_AND = 3'b001;
  localparam logic [2:0] AAA_EOR = 3'b010;
  localparam logic [2:0] AAA_ADC = 3'b011;
  localparam logic [2:0] AAA_STA = 3'b100;
  localparam logic [2:0] AAA_LDA = 3'b101;
  localparam logic [2:0] AAA_CMP = 3'b110;
  localparam logic [2:0] AAA_SBC = 3'b111;

  // Opcodes outside group 01, decoded as whole bytes
  localparam opcode_t OPC_BRK     = 8'h00;
  localparam opcode_t OPC_JMP_ABS = 8'h4c;
  localparam opcode_t OPC_LDX_IMM = 8'ha2;
  localparam opcode_t OPC_LDY_IMM = 8'ha0;
  localparam opcode_t OPC_STX_ZP  = 8'h86;
  localparam opcode_t OPC_STY_ZP  = 8'h84;
  localparam opcode_t OPC_INX     = 8'he8;
  localparam opcode_t OPC_INY     = 8'hc8;
  localparam opcode_t OPC_DEX     = 8'hca;
  localparam opcode_t OPC_DEY     = 8'h88;
  localparam opcode_t OPC_TAX     = 8'haa;
  localparam opcode_t OPC_TXA     = 8'h8a;
  localparam opcode_t OPC_TAY     = 8'ha8;
  localparam opcode_t OPC_TYA     = 8'h98;
  localparam opcode_t OPC_CLC     = 8'h18;
  localparam opcode_t OPC_SEC     = 8'h38;
  localparam opcode_t OPC_BPL     = 8'h10;
  localparam opcode_t OPC_BMI     = 8'h30;
  localparam opcode_t OPC_BCC     = 8'h90;
  localparam opcode_t OPC_BCS     = 8'hb0;
  localparam opcode_t OPC_BNE     = 8'hd0;
  localparam opcode_t OPC_BEQ     = 8'hf0;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
  } flags_t;

  typedef enum logic [4:0] {
    ALU_ORA, ALU_AND, ALU_EOR, ALU_ADC, ALU_SBC, ALU_CMP, ALU_LDA,
    ALU_LDX, ALU_LDY, ALU_INX, ALU_INY, ALU_DEX, ALU_DEY,
    ALU_TAX, ALU_TXA, ALU_TAY, ALU_TYA, ALU_CLC, ALU_SEC, ALU_NONE
  } alu_op_t;

  typedef enum logic [1:0] {
    STORE_A,
    STORE_X,
    STORE_Y
  } store_src_t;

  typedef enum logic [2:0] {
    SEQ_FETCH_OP,
    SEQ_FETCH_LO,
    SEQ_FETCH_HI,
    SEQ_READ_OP,
    SEQ_EXECUTE,
    SEQ_STORE,
    SEQ_HALTED,
    SEQ_ERROR
  } seq_state_t;

  typedef struct packed {
    alu_op_t op;
    byte_t   operand;
    logic    valid;
  } exec_cmd_t;

endpackage

//--- source/axi_lite_pkg.sv
// AXI4-Lite with 32-bit address and data; the core moves one byte per transaction
package axi_lite_pkg;

  typedef struct packed {
    logic [31:0] awaddr;
    logic        awvalid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        bready;
    logic [31:0] araddr;
    logic        arvalid;
    logic        rready;
  } axi_lite_req_t;

  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
  } axi_lite_rsp_t;

  // Byte access from the sequencer, held until done
  typedef struct packed {
    m6502_pkg::addr_t addr;
    logic             write;
    m6502_pkg::byte_t wdata;
    logic             valid;
  } mem_req_t;

  typedef struct packed {
    logic             done;
    m6502_pkg::byte_t rdata;
  } mem_rsp_t;

endpackage

//--- source/axi_lite_byte_master.sv
// One AXI4-Lite transaction at a time; the upper address bits are zero and responses are ignored
`timescale 1ns/1ns

module axi_lite_byte_master (
  input  logic                        raw_clk,
  input  logic                        button_reset,
  input  axi_lite_pkg::mem_req_t      mem_req,
  output axi_lite_pkg::mem_rsp_t      mem_rsp,
  output axi_lite_pkg::axi_lite_req_t bus_req,
  input  axi_lite_pkg::axi_lite_rsp_t bus_rsp
);

  typedef enum logic [1:0] {
    BUS_IDLE,
    BUS_ADDR,
    BUS_RESP
  } bus_state_t;

  bus_state_t       state;
  logic             write_q;
  logic             aw_ok;
  logic             w_ok;
  m6502_pkg::addr_t addr_q;
  m6502_pkg::byte_t wdata_q;
  logic             aw_hs;
  logic             w_hs;
  logic             ar_hs;

  // Valids and readies come straight from the state
  always_comb
  begin
    bus_req.awaddr  = {16'h0000, addr_q};
    bus_req.araddr  = {16'h0000, addr_q};
    bus_req.wdata   = {4{wdata_q}};
    bus_req.wstrb   = 4'b0001 << addr_q[1:0];
    bus_req.awvalid = (state == BUS_ADDR) && write_q && !aw_ok;
    bus_req.wvalid  = (state == BUS_ADDR) && write_q && !w_ok;
    bus_req.arvalid = (state == BUS_ADDR) && !write_q;
    bus_req.bready  = (state == BUS_RESP) && write_q;
    bus_req.rready  = (state == BUS_RESP) && !write_q;
  end

  assign aw_hs = bus_req.awvalid && bus_rsp.awready;
  assign w_hs  = bus_req.wvalid && bus_rsp.wready;
  assign ar_hs = bus_req.arvalid && bus_rsp.arready;

  // Done pulses in the B or R handshake cycle
  assign mem_rsp.done  = (state == BUS_RESP) && (write_q ? bus_rsp.bvalid : bus_rsp.rvalid);
  assign mem_rsp.rdata = bus_rsp.rdata[{addr_q[1:0], 3'b000} +: 8];

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      state <= BUS_IDLE;
      aw_ok <= 1'b0;
      w_ok  <= 1'b0;
    end
    else
    begin
      case (state)
        BUS_IDLE:
          if (mem_req.valid)
          begin
            addr_q  <= mem_req.addr;
            wdata_q <= mem_req.wdata;
            write_q <= mem_req.write;
            aw_ok   <= 1'b0;
            w_ok    <= 1'b0;
            state   <= BUS_ADDR;
          end
        BUS_ADDR:
          if (write_q)
          begin
            // AW and W may be accepted in either order
            if (aw_hs)
              aw_ok <= 1'b1;
            if (w_hs)
              w_ok <= 1'b1;
            if ((aw_ok || aw_hs) && (w_ok || w_hs))
              state <= BUS_RESP;
          end
          else if (ar_hs)
            state <= BUS_RESP;
        default:
          if (mem_rsp.done)
            state <= BUS_IDLE;
      endcase
    end
  end

endmodule

//--- source/cpu_sequencer.sv
// Opcodes outside the supported subset stop the core in the error state until reset
`timescale 1ns/1ns

module cpu_sequencer (
  input  logic                    raw_clk,
  input  logic                    button_reset,
  output axi_lite_pkg::mem_req_t  mem_req,
  input  axi_lite_pkg::mem_rsp_t  mem_rsp,
  output m6502_pkg::exec_cmd_t    exec_cmd,
  input  m6502_pkg::byte_t        reg_x,
  input  m6502_pkg::byte_t        reg_y,
  input  m6502_pkg::byte_t        store_data,
  input  m6502_pkg::flags_t       flags,
  output m6502_pkg::store_src_t   store_sel,
  output logic                    halted,
  output logic                    error
);

  typedef enum logic [2:0] {
    AM_NONE,
    AM_IMM,
    AM_ZP,
    AM_ABS,
    AM_ABS_X,
    AM_ABS_Y
  } amode_t;

  typedef struct packed {
    amode_t                mode;
    m6502_pkg::alu_op_t    op;
    m6502_pkg::store_src_t src;
    logic                  store;
    logic                  branch;
    logic                  jump;
    logic                  brk;
    logic                  illegal;
  } decode_t;

  m6502_pkg::seq_state_t state;
  m6502_pkg::addr_t      pc;
  m6502_pkg::addr_t      ea;
  m6502_pkg::opcode_t    opcode;
  m6502_pkg::byte_t      operand;
  m6502_pkg::byte_t      index;
  decode_t               dec;
  decode_t               new_dec;

  function automatic decode_t decode(m6502_pkg::opcode_t opc);
    decode_t d;
    d = '{mode: AM_NONE, op: m6502_pkg::ALU_NONE, src: m6502_pkg::STORE_A,
          store: 1'b0, branch: 1'b0, jump: 1'b0, brk: 1'b0, illegal: 1'b0};
    if (opc[1:0] == m6502_pkg::GRP_ALU)
    begin
      case (opc[4:2])
        m6502_pkg::MODE_ZP:    d.mode = AM_ZP;
        m6502_pkg::MODE_IMM:   d.mode = AM_IMM;
        m6502_pkg::MODE_ABS:   d.mode = AM_ABS;
        m6502_pkg::MODE_ABS_Y: d.mode = AM_ABS_Y;
        m6502_pkg::MODE_ABS_X: d.mode = AM_ABS_X;
        default:               d.illegal = 1'b1;
      endcase
      case (opc[7:5])
        m6502_pkg::AAA_ORA: d.op = m6502_pkg::ALU_ORA;
        m6502_pkg::AAA_AND: d.op = m6502_pkg::ALU_AND;
        m6502_pkg::AAA_EOR: d.op = m6502_pkg::ALU_EOR;
        m6502_pkg::AAA_ADC: d.op = m6502_pkg::ALU_ADC;
        m6502_pkg::AAA_STA: d.store = 1'b1;
        m6502_pkg::AAA_LDA: d.op = m6502_pkg::ALU_LDA;
        m6502_pkg::AAA_CMP: d.op = m6502_pkg::ALU_CMP;
        default:            d.op = m6502_pkg::ALU_SBC;
      endcase
      // STA has no immediate form
      if (d.store && d.mode == AM_IMM)
        d.illegal = 1'b1;
    end
    else
    begin
      case (opc)
        m6502_pkg::OPC_LDX_IMM:
        begin
          d.mode = AM_IMM;
          d.op   = m6502_pkg::ALU_LDX;
        end
        m6502_pkg::OPC_LDY_IMM:
        begin
          d.mode = AM_IMM;
          d.op   = m6502_pkg::ALU_LDY;
        end
        m6502_pkg::OPC_STX_ZP:
        begin
          d.mode  = AM_ZP;
          d.store = 1'b1;
          d.src   = m6502_pkg::STORE_X;
        end
        m6502_pkg::OPC_STY_ZP:
        begin
          d.mode  = AM_ZP;
          d.store = 1'b1;
          d.src   = m6502_pkg::STORE_Y;
        end
        m6502_pkg::OPC_INX: d.op = m6502_pkg::ALU_INX;
        m6502_pkg::OPC_INY: d.op = m6502_pkg::ALU_INY;
        m6502_pkg::OPC_DEX: d.op = m6502_pkg::ALU_DEX;
        m6502_pkg::OPC_DEY: d.op = m6502_pkg::ALU_DEY;
        m6502_pkg::OPC_TAX: d.op = m6502_pkg::ALU_TAX;
        m6502_pkg::OPC_TXA: d.op = m6502_pkg::ALU_TXA;
        m6502_pkg::OPC_TAY: d.op = m6502_pkg::ALU_TAY;
        m6502_pkg::OPC_TYA: d.op = m6502_pkg::ALU_TYA;
        m6502_pkg::OPC_CLC: d.op = m6502_pkg::ALU_CLC;
        m6502_pkg::OPC_SEC: d.op = m6502_pkg::ALU_SEC;
        m6502_pkg::OPC_BPL, m6502_pkg::OPC_BMI, m6502_pkg::OPC_BCC,
        m6502_pkg::OPC_BCS, m6502_pkg::OPC_BNE, m6502_pkg::OPC_BEQ:
        begin
          d.mode   = AM_IMM;
          d.branch = 1'b1;
        end
        m6502_pkg::OPC_JMP_ABS:
        begin
          d.mode = AM_ABS;
          d.jump = 1'b1;
        end
        m6502_pkg::OPC_BRK: d.brk = 1'b1;
        default:            d.illegal = 1'b1;
      endcase
    end
    return d;
  endfunction

  // Bits 7:6 pick the flag, bit 5 is the value that takes the branch
  function automatic logic branch_taken(m6502_pkg::opcode_t opc, m6502_pkg::flags_t f);
    logic flag;
    case (opc[7:6])
      2'b00:   flag = f.n;
      2'b10:   flag = f.c;
      2'b11:   flag = f.z;
      default: flag = 1'b0;
    endcase
    return flag == opc[5];
  endfunction

  assign dec     = decode(opcode);
  assign new_dec = decode(mem_rsp.rdata);
  assign index   = (dec.mode == AM_ABS_X) ? reg_x : ((dec.mode == AM_ABS_Y) ? reg_y : 8'h00);

  // The request is held by the state until done
  always_comb
  begin
    mem_req.valid = (state == m6502_pkg::SEQ_FETCH_OP) || (state == m6502_pkg::SEQ_FETCH_LO) ||
                    (state == m6502_pkg::SEQ_FETCH_HI) || (state == m6502_pkg::SEQ_READ_OP) ||
                    (state == m6502_pkg::SEQ_STORE);
    mem_req.write = (state == m6502_pkg::SEQ_STORE);
    mem_req.addr  = (state == m6502_pkg::SEQ_READ_OP || state == m6502_pkg::SEQ_STORE) ? ea : pc;
    mem_req.wdata = store_data;
  end

  assign exec_cmd.valid   = (state == m6502_pkg::SEQ_EXECUTE);
  assign exec_cmd.op      = dec.op;
  assign exec_cmd.operand = operand;
  assign store_sel        = dec.src;
  assign halted           = (state == m6502_pkg::SEQ_HALTED);
  assign error            = (state == m6502_pkg::SEQ_ERROR);

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      state <= m6502_pkg::SEQ_FETCH_OP;
      pc    <= m6502_pkg::RESET_PC;
    end
    else
    begin
      case (state)
        m6502_pkg::SEQ_FETCH_OP:
          if (mem_rsp.done)
          begin
            opcode <= mem_rsp.rdata;
            pc     <= pc + 16'd1;
            if (new_dec.illegal)
              state <= m6502_pkg::SEQ_ERROR;
            else if (new_dec.brk)
              state <= m6502_pkg::SEQ_HALTED;
            else if (new_dec.mode == AM_NONE)
              state <= m6502_pkg::SEQ_EXECUTE;
            else
              state <= m6502_pkg::SEQ_FETCH_LO;
          end
        m6502_pkg::SEQ_FETCH_LO:
          if (mem_rsp.done)
          begin
            operand <= mem_rsp.rdata;
            ea      <= {8'h00, mem_rsp.rdata};
            pc      <= pc + 16'd1;
            if (dec.branch)
            begin
              // Offset is relative to the byte after the operand
              if (branch_taken(opcode, flags))
                pc <= pc + 16'd1 + {{8{mem_rsp.rdata[7]}}, mem_rsp.rdata};
              state <= m6502_pkg::SEQ_FETCH_OP;
            end
            else if (dec.mode == AM_IMM)
              state <= m6502_pkg::SEQ_EXECUTE;
            else if (dec.mode == AM_ZP)
              state <= dec.store ? m6502_pkg::SEQ_STORE : m6502_pkg::SEQ_READ_OP;
            else
              state <= m6502_pkg::SEQ_FETCH_HI;
          end
        m6502_pkg::SEQ_FETCH_HI:
          if (mem_rsp.done)
          begin
            pc <= pc + 16'd1;
            ea <= {mem_rsp.rdata, operand} + {8'h00, index};
            if (dec.jump)
            begin
              pc    <= {mem_rsp.rdata, operand};
              state <= m6502_pkg::SEQ_FETCH_OP;
            end
            else
              state <= dec.store ? m6502_pkg::SEQ_STORE : m6502_pkg::SEQ_READ_OP;
          end
        m6502_pkg::SEQ_READ_OP:
          if (mem_rsp.done)
          begin
            operand <= mem_rsp.rdata;
            state   <= m6502_pkg::SEQ_EXECUTE;
          end
        m6502_pkg::SEQ_EXECUTE:
          state <= m6502_pkg::SEQ_FETCH_OP;
        m6502_pkg::SEQ_STORE:
          if (mem_rsp.done)
            state <= m6502_pkg::SEQ_FETCH_OP;
        default:
          state <= state;
      endcase
    end
  end

endmodule

//--- source/cpu_datapath.sv
// Binary arithmetic only; there is no overflow flag and no decimal mode
`timescale 1ns/1ns

module cpu_datapath (
  input  logic                  raw_clk,
  input  logic                  button_reset,
  input  m6502_pkg::exec_cmd_t  exec_cmd,
  input  m6502_pkg::store_src_t store_sel,
  output m6502_pkg::byte_t      reg_x,
  output m6502_pkg::byte_t      reg_y,
  output m6502_pkg::byte_t      store_data,
  output m6502_pkg::flags_t     flags
);

  m6502_pkg::byte_t  reg_a;
  m6502_pkg::byte_t  nxt_a;
  m6502_pkg::byte_t  nxt_x;
  m6502_pkg::byte_t  nxt_y;
  m6502_pkg::flags_t nxt_flags;
  m6502_pkg::byte_t  res;
  m6502_pkg::byte_t  b_in;
  logic              cin;
  logic              set_nz;
  logic [8:0]        sum;
  logic              subtract;

  // SBC and CMP add the inverted operand so carry means no borrow
  assign subtract = (exec_cmd.op == m6502_pkg::ALU_SBC) || (exec_cmd.op == m6502_pkg::ALU_CMP);
  assign b_in     = subtract ? ~exec_cmd.operand : exec_cmd.operand;
  assign cin      = (exec_cmd.op == m6502_pkg::ALU_CMP) ? 1'b1 : flags.c;
  assign sum      = {1'b0, reg_a} + {1'b0, b_in} + {8'h00, cin};

  always_comb
  begin
    nxt_a     = reg_a;
    nxt_x     = reg_x;
    nxt_y     = reg_y;
    nxt_flags = flags;
    res       = 8'h00;
    set_nz    = 1'b1;
    case (exec_cmd.op)
      m6502_pkg::ALU_ORA: res = reg_a | exec_cmd.operand;
      m6502_pkg::ALU_AND: res = reg_a & exec_cmd.operand;
      m6502_pkg::ALU_EOR: res = reg_a ^ exec_cmd.operand;
      m6502_pkg::ALU_ADC, m6502_pkg::ALU_SBC, m6502_pkg::ALU_CMP:
      begin
        res         = sum[7:0];
        nxt_flags.c = sum[8];
      end
      m6502_pkg::ALU_LDA, m6502_pkg::ALU_LDX, m6502_pkg::ALU_LDY: res = exec_cmd.operand;
      m6502_pkg::ALU_INX: res = reg_x + 8'd1;
      m6502_pkg::ALU_DEX: res = reg_x - 8'd1;
      m6502_pkg::ALU_INY: res = reg_y + 8'd1;
      m6502_pkg::ALU_DEY: res = reg_y - 8'd1;
      m6502_pkg::ALU_TAX, m6502_pkg::ALU_TAY: res = reg_a;
      m6502_pkg::ALU_TXA: res = reg_x;
      m6502_pkg::ALU_TYA: res = reg_y;
      m6502_pkg::ALU_CLC:
      begin
        nxt_flags.c = 1'b0;
        set_nz      = 1'b0;
      end
      m6502_pkg::ALU_SEC:
      begin
        nxt_flags.c = 1'b1;
        set_nz      = 1'b0;
      end
      default: set_nz = 1'b0;
    endcase

    // Destination register of the result; CMP writes none
    case (exec_cmd.op)
      m6502_pkg::ALU_ORA, m6502_pkg::ALU_AND, m6502_pkg::ALU_EOR, m6502_pkg::ALU_ADC,
      m6502_pkg::ALU_SBC, m6502_pkg::ALU_LDA, m6502_pkg::ALU_TXA, m6502_pkg::ALU_TYA:
        nxt_a = res;
      m6502_pkg::ALU_LDX, m6502_pkg::ALU_INX, m6502_pkg::ALU_DEX, m6502_pkg::ALU_TAX:
        nxt_x = res;
      m6502_pkg::ALU_LDY, m6502_pkg::ALU_INY, m6502_pkg::ALU_DEY, m6502_pkg::ALU_TAY:
        nxt_y = res;
      default:
        nxt_a = reg_a;
    endcase

    if (set_nz)
    begin
      nxt_flags.n = res[7];
      nxt_flags.z = (res == 8'h00);
    end
  end

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      reg_a <= 8'h00;
      reg_x <= 8'h00;
      reg_y <= 8'h00;
      flags <= '0;
    end
    else if (exec_cmd.valid)
    begin
      reg_a <= nxt_a;
      reg_x <= nxt_x;
      reg_y <= nxt_y;
      flags <= nxt_flags;
    end
  end

  always_comb
  begin
    case (store_sel)
      m6502_pkg::STORE_X: store_data = reg_x;
      m6502_pkg::STORE_Y: store_data = reg_y;
      default:            store_data = reg_a;
    endcase
  end

endmodule

//--- source/m6502_top.sv
// Core runs directly on raw_clk; all memory and I/O are reached over the AXI4-Lite port
`timescale 1ns/1ns

module m6502_top (
  input  logic                        raw_clk,
  input  logic                        button_reset,
  output axi_lite_pkg::axi_lite_req_t bus_req,
  input  axi_lite_pkg::axi_lite_rsp_t bus_rsp,
  output logic                        halted,
  output logic                        error
);

  axi_lite_pkg::mem_req_t  mem_req;
  axi_lite_pkg::mem_rsp_t  mem_rsp;
  m6502_pkg::exec_cmd_t    exec_cmd;
  m6502_pkg::store_src_t   store_sel;
  m6502_pkg::byte_t        reg_x;
  m6502_pkg::byte_t        reg_y;
  m6502_pkg::byte_t        store_data;
  m6502_pkg::flags_t       flags;

  cpu_sequencer u_seq (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .mem_req      (mem_req),
    .mem_rsp      (mem_rsp),
    .exec_cmd     (exec_cmd),
    .reg_x        (reg_x),
    .reg_y        (reg_y),
    .store_data   (store_data),
    .flags        (flags),
    .store_sel    (store_sel),
    .halted       (halted),
    .error        (error)
  );

  cpu_datapath u_dp (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .exec_cmd     (exec_cmd),
    .store_sel    (store_sel),
    .reg_x        (reg_x),
    .reg_y        (reg_y),
    .store_data   (store_data),
    .flags        (flags)
  );

  axi_lite_byte_master u_bus (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .mem_req      (mem_req),
    .mem_rsp      (mem_rsp),
    .bus_req      (bus_req),
    .bus_rsp      (bus_rsp)
  );

endmodule

//--- verification/m6502_props.sv
// Checks only the master side of AXI4-Lite; slave timing is left to the memory model
`timescale 1ns/1ns

module m6502_props (
  input logic                        raw_clk,
  input logic                        button_reset,
  input axi_lite_pkg::axi_lite_req_t bus_req,
  input axi_lite_pkg::axi_lite_rsp_t bus_rsp
);

  // Read address held until accepted
  assert property (@(posedge raw_clk) disable iff (!button_reset)
    bus_req.arvalid && !bus_rsp.arready |=> bus_req.arvalid && $stable(bus_req.araddr))
    else $error("arvalid dropped or araddr changed before arready");

  assert property (@(posedge raw_clk) disable iff (!button_reset)
    bus_req.awvalid && !bus_rsp.awready |=> bus_req.awvalid && $stable(bus_req.awaddr))
    else $error("awvalid dropped or awaddr changed before awready");

  assert property (@(posedge raw_clk) disable iff (!button_reset)
    bus_req.wvalid && !bus_rsp.wready |=>
      bus_req.wvalid && $stable(bus_req.wdata) && $stable(bus_req.wstrb))
    else $error("wvalid dropped or write payload changed before wready");

  // Single byte lane per write
  assert property (@(posedge raw_clk) disable iff (!button_reset)
    bus_req.wvalid |-> $onehot(bus_req.wstrb))
    else $error("wstrb is not one-hot");

  // First reset cycle is skipped while the state settles
  assert property (@(posedge raw_clk)
    !button_reset && !$past(button_reset) |->
      !bus_req.arvalid && !bus_req.awvalid && !bus_req.wvalid)
    else $error("valid output high during reset");

endmodule

bind axi_lite_byte_master m6502_props u_props (
  .raw_clk      (raw_clk),
  .button_reset (button_reset),
  .bus_req      (bus_req),
  .bus_rsp      (bus_rsp)
);

//--- verification/m6502_tb.sv
// Memory model answers the whole 64 KB space; the program at 16'h4000 must end in BRK
`timescale 1ns/1ns

module m6502_tb;

  typedef struct packed {
    logic ar_hs;
    logic aw_hs;
    logic w_hs;
    logic r_hs;
    logic b_hs;
  } hs_t;

  localparam int WATCHDOG_CYCLES = 200 * 10;
  localparam int NUM_WRITES = 14;

  logic                        raw_clk = 1'b0;
  logic                        button_reset;
  axi_lite_pkg::axi_lite_req_t bus_req;
  axi_lite_pkg::axi_lite_rsp_t bus_rsp;
  logic                        halted;
  logic                        error;

  m6502_pkg::byte_t mem [0:65535];
  m6502_pkg::byte_t prog [0:74];
  m6502_pkg::addr_t exp_addr [0:NUM_WRITES-1];
  m6502_pkg::byte_t exp_data [0:NUM_WRITES-1];
  axi_lite_pkg::axi_lite_req_t req_s;
  hs_t              hs_s;
  logic [31:0]      rng_state = 32'hdcc2;
  logic [1:0]       ar_stall;
  logic [1:0]       aw_stall;
  logic [1:0]       w_stall;
  logic [1:0]       rd_wait;
  logic [1:0]       wr_wait;
  logic             rd_pend;
  logic             wr_pend;
  logic             have_aw;
  logic             have_w;
  logic             first_read_seen;
  m6502_pkg::addr_t rd_addr;
  m6502_pkg::addr_t rd_base;
  m6502_pkg::addr_t wr_addr;
  logic [31:0]      wr_word;
  logic [3:0]       wr_strb;
  int               wr_count = 0;

  m6502_top u_dut (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .bus_req      (bus_req),
    .bus_rsp      (bus_rsp),
    .halted       (halted),
    .error        (error)
  );

  always #50 raw_clk = ~raw_clk;

  task automatic report_mismatch(string sig, logic [31:0] got, logic [31:0] exp);
    $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, sig, got, exp);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic abort_run(string why);
    $display("%s at %0t ns", why, $time);
    $display("Verification failed");
    $fatal(1);
  endtask

  // LCG step giving 0 to 3 stall cycles
  function automatic logic [1:0] next_stall();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state[17:16];
  endfunction

  // One-hot byte strobe for an address lane
  function automatic logic [3:0] lane_strobe(logic [1:0] lane);
    case (lane)
      2'd0:    return 4'b0001;
      2'd1:    return 4'b0010;
      2'd2:    return 4'b0100;
      default: return 4'b1000;
    endcase
  endfunction

  // An unsupported opcode would park the core in the error state
  assert property (@(posedge raw_clk) disable iff (!button_reset) !error)
    else report_mismatch("error", 32'(error), 32'h0);

  initial
  begin
    for (int i = 0; i < 65536; i++)
      mem[i] = i[7:0] ^ i[15:8] ^ 8'h5a;
    prog = '{8'h38, 8'ha9, 8'h35, 8'h69, 8'h10, 8'h85, 8'h10,              // SEC, ADC
             8'h18, 8'h69, 8'hc0, 8'h85, 8'h11, 8'h09, 8'hf0, 8'h85, 8'h12, // CLC, ADC, ORA
             8'h29, 8'h3c, 8'h85, 8'h13, 8'h49, 8'hff, 8'h85, 8'h14,        // AND, EOR
             8'h38, 8'he9, 8'h0b, 8'h85, 8'h15,                             // SBC
             8'ha2, 8'h03, 8'ha0, 8'h06, 8'he8, 8'h88, 8'h98,               // LDX, LDY, TYA
             8'h9d, 8'h00, 8'h02, 8'ha9, 8'h77, 8'haa,                      // STA abs,X
             8'h99, 8'h00, 8'h03, 8'h86, 8'h20, 8'ha8, 8'h84, 8'h21,        // STA abs,Y
             8'ha2, 8'h03, 8'h86, 8'h30, 8'hca, 8'hd0, 8'hfb,               // DEX loop
             8'hf0, 8'h02, 8'h85, 8'h40,                                    // BEQ over poison
             8'ha9, 8'h10, 8'hc9, 8'h08, 8'h90, 8'h02, 8'h85, 8'h41,        // BCC not taken
             8'h4c, 8'h4a, 8'h40, 8'h85, 8'h42, 8'h00};                     // JMP, BRK
    for (int i = 0; i < 75; i++)
      mem[16'h4000 + i[15:0]] = prog[i];
    // 35+10+C, 46+c0, 06|f0, f6&3c, 34^ff, cb-0b, then Y=5 at 0200+X, X=77 at 0300+Y
    exp_addr = '{16'h0010, 16'h0011, 16'h0012, 16'h0013, 16'h0014, 16'h0015, 16'h0204,
                 16'h0305, 16'h0020, 16'h0021, 16'h0030, 16'h0030, 16'h0030, 16'h0041};
    exp_data = '{8'h46, 8'h06, 8'hf6, 8'h34, 8'hcb, 8'hc0, 8'h05,
                 8'h77, 8'h77, 8'h77, 8'h03, 8'h02, 8'h01, 8'h10};
    button_reset = 1'b0;
    bus_rsp = '0;
    repeat (5) @(posedge raw_clk);
    #1 button_reset = 1'b1;
    wait (halted);
    // Quiet window to see that nothing follows BRK
    repeat (20) @(posedge raw_clk);
    if (wr_count == NUM_WRITES)
    begin
      $display("Verification passed");
      $finish;
    end
    else
      report_mismatch("write count", 32'(wr_count), 32'(NUM_WRITES));
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge raw_clk);
    abort_run("Timeout: the core did not reach BRK in the allowed cycles");
  end

  // Handshakes are judged on stable values between edges
  always @(negedge raw_clk)
  begin
    req_s = bus_req;
    hs_s.ar_hs = bus_req.arvalid && bus_rsp.arready;
    hs_s.aw_hs = bus_req.awvalid && bus_rsp.awready;
    hs_s.w_hs  = bus_req.wvalid && bus_rsp.wready;
    hs_s.r_hs  = bus_req.rready && bus_rsp.rvalid;
    hs_s.b_hs  = bus_req.bready && bus_rsp.bvalid;
    if (halted && (bus_req.arvalid || bus_req.awvalid || bus_req.wvalid))
      abort_run("Bus transaction issued after the core halted");
  end

  always @(posedge raw_clk)
  begin
    #1;
    if (!button_reset)
    begin
      bus_rsp = '0;
      {ar_stall, aw_stall, w_stall, rd_wait, wr_wait} = '0;
      {rd_pend, wr_pend, have_aw, have_w, first_read_seen} = '0;
    end
    else
    begin
      if (hs_s.ar_hs)
      begin
        if (!first_read_seen)
        begin
          assert (req_s.araddr == {16'h0000, m6502_pkg::RESET_PC})
            else report_mismatch("araddr", req_s.araddr, {16'h0000, m6502_pkg::RESET_PC});
          assert (!halted && !error)
            else report_mismatch("halted/error", {30'h0, halted, error}, 32'h0);
          first_read_seen = 1'b1;
        end
        rd_addr  = req_s.araddr[15:0];
        rd_pend  = 1'b1;
        rd_wait  = next_stall();
        ar_stall = next_stall();
      end
      else if (req_s.arvalid && ar_stall != 2'd0)
        ar_stall = ar_stall - 2'd1;
      if (hs_s.r_hs)
        bus_rsp.rvalid = 1'b0;
      else if (rd_pend && !bus_rsp.rvalid)
      begin
        if (rd_wait == 2'd0)
        begin
          rd_base = {rd_addr[15:2], 2'b00};
          bus_rsp.rdata = {mem[rd_base + 16'd3], mem[rd_base + 16'd2],
                           mem[rd_base + 16'd1], mem[rd_base]};
          bus_rsp.rvalid = 1'b1;
          rd_pend = 1'b0;
        end
        else
          rd_wait = rd_wait - 2'd1;
      end
      if (hs_s.aw_hs)
      begin
        wr_addr  = req_s.awaddr[15:0];
        have_aw  = 1'b1;
        aw_stall = next_stall();
      end
      else if (req_s.awvalid && aw_stall != 2'd0)
        aw_stall = aw_stall - 2'd1;
      if (hs_s.w_hs)
      begin
        wr_word = req_s.wdata;
        wr_strb = req_s.wstrb;
        have_w  = 1'b1;
        w_stall = next_stall();
      end
      else if (req_s.wvalid && w_stall != 2'd0)
        w_stall = w_stall - 2'd1;
      if (have_aw && have_w)
      begin
        {have_aw, have_w} = 2'b00;
        wr_pend = 1'b1;
        wr_wait = next_stall();
      end
      if (hs_s.b_hs)
      begin
        bus_rsp.bvalid = 1'b0;
        if (wr_count >= NUM_WRITES)
          abort_run("More writes than the program performs");
        else
        begin
          assert (wr_addr == exp_addr[wr_count])
            else report_mismatch("awaddr", 32'(wr_addr), 32'(exp_addr[wr_count]));
          assert (wr_strb == lane_strobe(wr_addr[1:0]))
            else report_mismatch("wstrb", 32'(wr_strb), 32'(lane_strobe(wr_addr[1:0])));
          assert (wr_word[{wr_addr[1:0], 3'b000} +: 8] == exp_data[wr_count])
            else report_mismatch("wdata", 32'(wr_word[{wr_addr[1:0], 3'b000} +: 8]),
                                 32'(exp_data[wr_count]));
          mem[wr_addr] = wr_word[{wr_addr[1:0], 3'b000} +: 8];
          wr_count = wr_count + 1;
        end
      end
      else if (wr_pend && !bus_rsp.bvalid)
      begin
        if (wr_wait == 2'd0)
        begin
          bus_rsp.bvalid = 1'b1;
          wr_pend = 1'b0;
        end
        else
          wr_wait = wr_wait - 2'd1;
      end
      bus_rsp.arready = (ar_stall == 2'd0);
      bus_rsp.awready = (aw_stall == 2'd0);
      bus_rsp.wready  = (w_stall == 2'd0);
    end
  end

endmodule

//--- all.f
source/m6502_pkg.sv
source/axi_lite_pkg.sv
source/axi_lite_byte_master.sv
source/cpu_sequencer.sv
source/cpu_datapath.sv
source/m6502_top.sv
verification/m6502_props.sv
verification/m6502_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= m6502_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
